// ==== Bender.yml ====
package:
  name: alu_unit

sources:
  - files:
      - design/alu_pkg.sv
      - design/alu_bcd_nibble.sv
      - design/alu_core.sv
      - design/alu_ctrl.sv
      - design/alu_unit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_alu_unit.sv

// ==== design/alu_bcd_nibble.sv ====
`timescale 1ns/1ps

module alu_bcd_nibble (
	input  logic       add_adj,
	input  logic       sub_adj,
	input  logic [3:0] digit,
	output logic [3:0] adjusted
);

	// Same correction for both nibbles, selected by that nibble's carry
	always_comb begin
		adjusted = digit;
		if (add_adj) begin
			adjusted = digit + 4'd6; // Wraps past 15
		end else if (sub_adj) begin
			adjusted = digit - 4'd6;
		end
	end

	// Add and subtract adjust come from different decoded ops in the core
	a_adj_exclusive: assert final ($isunknown({add_adj, sub_adj}) || !(add_adj && sub_adj))
		else $error("BCD nibble asked to adjust up and down at once");

endmodule

// ==== design/alu_core.sv ====
`timescale 1ns/1ps

module alu_core
	import alu_pkg::*;
#(
	parameter bit DECIMAL_EN = 1'b1
) (
	input  logic      phi2,
	input  logic      rst_n,
	input  logic      start,
	input  alu_byte_u ai,
	input  alu_byte_u bi,
	input  alu_op_e   op,
	input  logic      carry_in,
	input  logic      decimal,
	output alu_byte_u core_result,
	output logic      core_carry,
	output logic      core_overflow
);

	logic [7:0] b_eff;
	logic [7:0] and_t;
	logic [7:0] or_t;
	logic [7:0] xor_t;
	logic [4:0] sum_lo;
	logic [3:0] sum_mid;
	logic [3:0] sum_bin;
	logic       dc_lo;
	logic       dc_hi;
	logic       c_hi_in;
	logic       c7;
	logic       s7;
	logic       cb7;
	logic       c7_bin;
	logic       cb7_bin;
	logic       c_lo;
	logic       c_out;
	logic       v;
	logic [7:0] sel;
	logic       dec_add;
	logic       dec_sub;

	alu_byte_u  res_q;
	logic       c_lo_q;
	logic       c_out_q;
	logic       v_q;
	logic       daa_q;
	logic       dsa_q;
	logic [3:0] adj_lo;
	logic [3:0] adj_hi;

	assign dec_add = DECIMAL_EN && decimal && (op == op_add);
	assign dec_sub = DECIMAL_EN && decimal && (op == op_sub);

	always_comb begin
		b_eff = (op == op_sub) ? ~bi.bin : bi.bin;
		and_t = ai.bin & b_eff;
		or_t  = ai.bin | b_eff;
		xor_t = ai.bin ^ b_eff;

		// Low nibble, decimal carry when the digit sum passes nine
		sum_lo  = {1'b0, ai.bin[3:0]} + {1'b0, b_eff[3:0]} + 5'(carry_in);
		dc_lo   = sum_lo > 5'd9;
		c_lo    = dec_add ? dc_lo : sum_lo[4];
		c_hi_in = c_lo; // Fast decimal carry injected into the high nibble

		// Bits 6..4 split off so the carry into bit 7 is visible
		sum_mid = {1'b0, ai.bin[6:4]} + {1'b0, b_eff[6:4]} + 4'(c_hi_in);
		c7      = sum_mid[3];
		s7      = xor_t[7] ^ c7;
		cb7     = and_t[7] | (c7 & xor_t[7]);
		dc_hi   = {cb7, s7, sum_mid[2:0]} > 5'd9;

		// Plain binary chain, overflow ignores the decimal carry
		sum_bin = {1'b0, ai.bin[6:4]} + {1'b0, b_eff[6:4]} + 4'(sum_lo[4]);
		c7_bin  = sum_bin[3];
		cb7_bin = and_t[7] | (c7_bin & xor_t[7]);

		// Flags come from the adder chain for every op
		c_out = dec_add ? dc_hi : cb7;
		v     = c7_bin ^ cb7_bin;

		case (op)
			op_add, op_sub: sel = {s7, sum_mid[2:0], sum_lo[3:0]};
			op_and:         sel = and_t;
			op_or:          sel = or_t;
			op_eor:         sel = xor_t;
			op_lsr:         sel = {1'b0, and_t[7:1]};
			default:        sel = '0;
		endcase
	end

	// Decimal mode of the op in the hold register
	always_ff @(posedge phi2) begin
		if (!rst_n) begin
			daa_q <= 1'b0;
			dsa_q <= 1'b0;
		end else if (start) begin
			daa_q <= dec_add;
			dsa_q <= dec_sub;
		end
	end

	// Adder hold, loaded the cycle after start
	always_ff @(posedge phi2) begin
		if (start) begin
			res_q.bin <= sel;
			c_lo_q    <= c_lo;
			c_out_q   <= c_out;
			v_q       <= v;
		end
	end

	// Up on decimal carry, down on borrow
	alu_bcd_nibble i_bcd_lo (
		.add_adj  (daa_q & c_lo_q),
		.sub_adj  (dsa_q & ~c_lo_q),
		.digit    (res_q.bcd.lo),
		.adjusted (adj_lo)
	);

	alu_bcd_nibble i_bcd_hi (
		.add_adj  (daa_q & c_out_q),
		.sub_adj  (dsa_q & ~c_out_q),
		.digit    (res_q.bcd.hi),
		.adjusted (adj_hi)
	);

	assign core_result.bin = {adj_hi, adj_lo};
	assign core_carry      = c_out_q;
	assign core_overflow   = v_q; // Binary overflow, also in decimal mode

	a_op_legal: assert property (@(posedge phi2) disable iff (!rst_n)
		start |-> op inside {op_add, op_sub, op_and, op_or, op_eor, op_lsr})
		else $error("Undefined ALU op issued");

endmodule

// ==== design/alu_ctrl.sv ====
`timescale 1ns/1ps

module alu_ctrl
	import alu_pkg::*;
(
	input  logic       phi2,
	input  logic       rst_n,
	input  logic       req,
	output logic       ack,
	input  alu_op_e    op_in,
	input  logic       use_acc,
	input  logic       carry_in_in,
	input  logic       decimal_in,
	input  logic [7:0] a,
	input  logic [7:0] b,
	output alu_byte_u  ai,
	output alu_byte_u  bi,
	output alu_op_e    op,
	output logic       carry_in,
	output logic       decimal,
	output logic       start,
	input  alu_byte_u  core_result,
	input  logic       core_carry,
	input  logic       core_overflow,
	output logic [7:0] result,
	output logic       carry_out,
	output logic       overflow
);

	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_compute = 2'd1; // Core loads its hold register
	localparam logic [1:0] st_hold    = 2'd2; // BCD correction settles
	localparam logic [1:0] st_ack     = 2'd3;

	logic [1:0] state;
	logic [7:0] acc;
	logic       take;

	assign take = (state == st_idle) && req;

	always_ff @(posedge phi2) begin
		if (!rst_n) begin
			state     <= st_idle;
			start     <= 1'b0;
			ack       <= 1'b0;
			acc       <= '0;
			carry_out <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				st_idle: begin
					if (req) begin
						state <= st_compute;
						start <= 1'b1;
					end
				end
				st_compute: state <= st_hold;
				st_hold: begin
					state     <= st_ack;
					ack       <= 1'b1;
					acc       <= core_result.bin; // Write back
					carry_out <= core_carry;
					overflow  <= core_overflow;
				end
				default: begin
					// Hold everything until the requester lets go
					if (!req) begin
						state <= st_idle;
						ack   <= 1'b0;
					end
				end
			endcase
		end
	end

	// Operand and control capture on the sampling edge
	always_ff @(posedge phi2) begin
		if (take) begin
			ai.bin   <= use_acc ? acc : a;
			bi.bin   <= b;
			op       <= op_in;
			carry_in <= carry_in_in;
			decimal  <= decimal_in;
		end
	end

	assign result = acc; // Accumulator doubles as result register

	a_ack_after_req: assert property (@(posedge phi2) disable iff (!rst_n)
		$rose(ack) |-> $past(req) && $past(req, ALU_LATENCY))
		else $error("ack raised without a held request");

	a_ack_release: assert property (@(posedge phi2) disable iff (!rst_n)
		ack && !req |=> !ack)
		else $error("ack still high after req fell");

endmodule

// ==== design/alu_pkg.sv ====
package alu_pkg;

	// Operation select, shared by controller, core and testbench
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1, // B inverted into the adder
		op_and = 3'd2,
		op_or  = 3'd3,
		op_eor = 3'd4,
		op_lsr = 3'd5  // (A AND B) >> 1
	} alu_op_e;

	// Operand/result word, binary byte or two packed BCD digits
	typedef union packed {
		logic [7:0] bin;
		struct packed {
			logic [3:0] hi;
			logic [3:0] lo;
		} bcd;
	} alu_byte_u;

	// Edges from the req sampling edge until ack is seen high
	localparam int unsigned ALU_LATENCY = 3;

endpackage

// ==== design/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
	import alu_pkg::*;
#(
	parameter bit DECIMAL_EN = 1'b1
) (
	input  logic       phi2,
	input  logic       rst_n,
	input  logic       req,
	output logic       ack,
	input  alu_op_e    op,
	input  logic       use_acc,
	input  logic       carry_in,
	input  logic       decimal,
	input  logic [7:0] a,
	input  logic [7:0] b,
	output logic [7:0] result,
	output logic       carry_out,
	output logic       overflow
);

	alu_byte_u core_ai;
	alu_byte_u core_bi;
	alu_op_e   core_op;
	logic      core_carry_in;
	logic      core_decimal;
	logic      start;
	alu_byte_u core_result;
	logic      core_carry;
	logic      core_overflow;

	alu_ctrl i_ctrl (
		.phi2          (phi2),
		.rst_n         (rst_n),
		.req           (req),
		.ack           (ack),
		.op_in         (op),
		.use_acc       (use_acc),
		.carry_in_in   (carry_in),
		.decimal_in    (decimal),
		.a             (a),
		.b             (b),
		.ai            (core_ai),
		.bi            (core_bi),
		.op            (core_op),
		.carry_in      (core_carry_in),
		.decimal       (core_decimal),
		.start         (start),
		.core_result   (core_result),
		.core_carry    (core_carry),
		.core_overflow (core_overflow),
		.result        (result),
		.carry_out     (carry_out),
		.overflow      (overflow)
	);

	alu_core #(
		.DECIMAL_EN (DECIMAL_EN)
	) i_core (
		.phi2          (phi2),
		.rst_n         (rst_n),
		.start         (start),
		.ai            (core_ai),
		.bi            (core_bi),
		.op            (core_op),
		.carry_in      (core_carry_in),
		.decimal       (core_decimal),
		.core_result   (core_result),
		.core_carry    (core_carry),
		.core_overflow (core_overflow)
	);

endmodule

// ==== list.f ====
+incdir+test
design/alu_pkg.sv
design/alu_bcd_nibble.sv
design/alu_core.sv
design/alu_ctrl.sv
design/alu_unit.sv
test/tb_alu_unit.sv

// ==== test/alu_ref.svh ====
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// Expected result and flags for one request
function automatic void expected_alu(
	input  alu_op_e    op,
	input  logic [7:0] a,
	input  logic [7:0] b,
	input  logic       cin,
	input  logic       dec,
	output logic [7:0] res,
	output logic       carry,
	output logic       ovf
);
	logic [7:0] b_add;
	int         total;
	int         signed_total;
	int         da;
	int         db;

	b_add = (op == op_sub) ? ~b : b; // Subtract adds the complement
	total = int'(a) + int'(b_add) + int'(cin);
	signed_total = int'($signed(a)) + int'($signed(b_add)) + int'(cin);
	res = total[7:0];
	carry = total > 255;
	ovf = (signed_total > 127) || (signed_total < -128); // Taken from the binary sum

	da = a[7:4] * 10 + a[3:0];
	db = b[7:4] * 10 + b[3:0];
	if (dec && op == op_add) begin
		total = da + db + int'(cin);
		carry = total > 99;
		total = total % 100;
		res = {4'(total / 10), 4'(total % 10)};
	end else if (dec && op == op_sub) begin
		total = da - db - int'(!cin);
		carry = total >= 0; // Set means no borrow
		total = (total + 100) % 100;
		res = {4'(total / 10), 4'(total % 10)};
	end

	case (op)
		op_and:  res = a & b;
		op_or:   res = a | b;
		op_eor:  res = a ^ b;
		op_lsr:  res = (a & b) >> 1;
		default: ;
	endcase
endfunction

`endif

// ==== test/tb_alu_unit.sv ====
`timescale 1ns/1ps

module tb_alu_unit
	import alu_pkg::*;
();

	`include "alu_ref.svh"

	localparam int NUM_TXN        = 400;
	localparam int TIMEOUT_CYCLES = NUM_TXN * 8 + 100;

	logic       phi2;
	logic       rst_n;
	logic       req;
	logic       ack;
	alu_op_e    op;
	logic       use_acc;
	logic       carry_in;
	logic       decimal;
	logic [7:0] a;
	logic [7:0] b;
	logic [7:0] result;
	logic       carry_out;
	logic       overflow;

	// Last request, as the compare process sees it
	alu_op_e    txn_op;
	logic [7:0] txn_a;
	logic [7:0] txn_b;
	logic       txn_cin;
	logic       txn_dec;
	int         txn_latency;
	event       txn_done;

	logic [7:0] model_acc;
	int         error_count;
	int         txn_count;
	int         cycle_count;
	string      test_name;
	int         test_errors;
	int         test_txns;

	alu_unit #(
		.DECIMAL_EN (1'b1)
	) i_dut (
		.phi2      (phi2),
		.rst_n     (rst_n),
		.req       (req),
		.ack       (ack),
		.op        (op),
		.use_acc   (use_acc),
		.carry_in  (carry_in),
		.decimal   (decimal),
		.a         (a),
		.b         (b),
		.result    (result),
		.carry_out (carry_out),
		.overflow  (overflow)
	);

	initial begin
		phi2 = 1'b0;
		forever #4 phi2 = ~phi2;
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge phi2);
			cycle_count++;
		end
		$display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = error_count;
		test_txns = txn_count;
	endtask

	task automatic finish_test();
		$display("%s: %0d transactions, %0d errors", test_name,
			txn_count - test_txns, error_count - test_errors);
	endtask

	function automatic logic [7:0] random_bcd();
		return {4'($urandom_range(0, 9)), 4'($urandom_range(0, 9))};
	endfunction

	// One four-phase transaction, entered 1 ns after a rising edge
	task automatic run_op(input alu_op_e op_v, input logic use_acc_v, input logic [7:0] a_v,
			input logic [7:0] b_v, input logic cin_v, input logic dec_v, input int hold);
		int         edges;
		logic [7:0] held;
		logic       held_c;
		logic       held_v;

		op = op_v;
		use_acc = use_acc_v;
		a = a_v;
		b = b_v;
		carry_in = cin_v;
		decimal = dec_v;
		req = 1'b1;
		edges = 0;
		do begin
			@(posedge phi2);
			#1;
			edges++;
		end while (!ack);
		txn_op = op_v;
		txn_a = use_acc_v ? model_acc : a_v;
		txn_b = b_v;
		txn_cin = cin_v;
		txn_dec = dec_v;
		txn_latency = edges;
		-> txn_done;

		held = result;
		held_c = carry_out;
		held_v = overflow;
		repeat (hold) begin
			@(posedge phi2);
			#1;
			assert (ack && result === held && carry_out === held_c && overflow === held_v)
				else report_mismatch("outputs changed while req was held high");
		end
		req = 1'b0;
		@(posedge phi2);
		#1;
		assert (!ack) else report_mismatch("ack still high one edge after req fell");
		while (ack) begin
			@(posedge phi2);
			#1;
		end
		txn_count++;
	endtask

	// Compare process
	initial begin
		logic [7:0] exp_res;
		logic       exp_c;
		logic       exp_v;
		logic       arith;

		forever begin
			@(txn_done);
			expected_alu(txn_op, txn_a, txn_b, txn_cin, txn_dec, exp_res, exp_c, exp_v);
			arith = (txn_op == op_add) || (txn_op == op_sub);
			assert (result === exp_res) else report_mismatch($sformatf(
				"%s a=%h b=%h c=%b d=%b result %h, expected %h", txn_op.name(),
				txn_a, txn_b, txn_cin, txn_dec, result, exp_res));
			assert (!arith || carry_out === exp_c) else report_mismatch($sformatf(
				"%s a=%h b=%h carry %b, expected %b", txn_op.name(), txn_a, txn_b,
				carry_out, exp_c));
			assert (!arith || overflow === exp_v) else report_mismatch($sformatf(
				"%s a=%h b=%h d=%b overflow %b, expected %b", txn_op.name(), txn_a, txn_b,
				txn_dec, overflow, exp_v));
			assert (txn_latency == ALU_LATENCY) else report_mismatch($sformatf(
				"ack after %0d edges, expected %0d", txn_latency, ALU_LATENCY));
			model_acc = exp_res; // Every op writes back
		end
	end

	initial begin
		logic [7:0] first_b;
		logic       first_c;

		void'($urandom(32'h654c));
		rst_n = 1'b0;
		req = 1'b0;
		op = op_add;
		use_acc = 1'b0;
		carry_in = 1'b0;
		decimal = 1'b0;
		a = '0;
		b = '0;
		error_count = 0;
		txn_count = 0;
		model_acc = '0;
		repeat (4) @(posedge phi2);
		#1;
		rst_n = 1'b1;

		start_test("reset");
		assert (ack === 1'b0 && result === 8'h00 && carry_out === 1'b0 && overflow === 1'b0)
			else report_mismatch("outputs not cleared by reset");
		first_b = 8'($urandom);
		first_c = 1'($urandom);
		run_op(op_add, 1'b1, 8'($urandom), first_b, first_c, 1'b0, 0);
		assert (result === 8'(first_b + first_c)) else report_mismatch($sformatf(
			"first accumulator add gave %h, expected %h", result, 8'(first_b + first_c)));
		finish_test();

		start_test("binary add/sub");
		repeat (150) run_op($urandom_range(0, 1) ? op_sub : op_add, 1'b0, 8'($urandom),
			8'($urandom), 1'($urandom), 1'b0, 0);
		finish_test();

		start_test("logic ops");
		repeat (60) run_op(alu_op_e'($urandom_range(2, 5)), 1'b0, 8'($urandom),
			8'($urandom), 1'($urandom), 1'($urandom), 0);
		finish_test();

		start_test("decimal add/sub");
		run_op(op_add, 1'b0, 8'h99, 8'h01, 1'b0, 1'b1, 0); // Wraps to 00
		run_op(op_sub, 1'b0, 8'h00, 8'h01, 1'b1, 1'b1, 0); // Wraps to 99
		repeat (98) run_op($urandom_range(0, 1) ? op_sub : op_add, 1'b0, random_bcd(),
			random_bcd(), 1'($urandom), 1'b1, 0);
		finish_test();

		start_test("accumulator chain");
		repeat (50) run_op(alu_op_e'($urandom_range(0, 5)), 1'b1, 8'($urandom),
			8'($urandom), 1'($urandom), 1'b0, 0);
		finish_test();

		start_test("handshake");
		repeat (20) run_op(op_add, 1'b0, 8'($urandom), 8'($urandom), 1'($urandom), 1'b0,
			$urandom_range(0, 10));
		finish_test();

		$display("Summary: %0d transactions, %0d errors", txn_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
